//--- src/intr_pkg.sv
// Interrupt aggregator definitions
package intr_pkg;

    // ------------------------------
    // Source numbering
    // ------------------------------
    // Block order is aes, ecc, hmac, sha512, mbox
    localparam int NUM_BLOCKS  = 5;
    localparam int SRC_PER_BLK = 2;                         // error then notif
    localparam int NUM_SRC     = NUM_BLOCKS * SRC_PER_BLK;  // Default source count

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int SRC_IDX_W = 4;  // Flat source index
    localparam int BLK_W     = 3;  // Block number within an index
    localparam int VEC_W     = 5;  // Core external interrupt number

    // Source index word
    //   flat : ordering key, lower wins
    //   src  : block number over error/notif kind
    typedef union packed {
        logic [SRC_IDX_W-1:0] flat;
        struct packed {
            logic [BLK_W-1:0] blk;
            logic             kind;  // 1 for notif
        } src;
    } src_idx_u;

endpackage

//--- src/intr_capture.sv
// Interrupt edge capture
module intr_capture #(
    parameter int NUM_BLOCKS = intr_pkg::NUM_BLOCKS
) (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic [intr_pkg::SRC_PER_BLK*NUM_BLOCKS-1:0]  src_i,
    input  logic                                         claim_valid_i,
    input  intr_pkg::src_idx_u                           claim_idx_i,
    output logic [intr_pkg::SRC_PER_BLK*NUM_BLOCKS-1:0]  pending_o
);

    import intr_pkg::*;

    localparam int N_SRC = SRC_PER_BLK * NUM_BLOCKS;

    logic [N_SRC-1:0] src_q;      // Sampled levels
    logic [N_SRC-1:0] src_d;      // Levels one cycle earlier
    logic [N_SRC-1:0] rise;
    logic [N_SRC-1:0] clr;
    logic [N_SRC-1:0] pending_q;

    assign rise = src_q & ~src_d;

    // One-hot clear of the claimed source
    always_comb begin
        clr = '0;
        if (claim_valid_i) begin
            clr[claim_idx_i.flat] = 1'b1;
        end
    end

    // ------------------------------
    // Level history and pending bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            src_q     <= '0;
            src_d     <= '0;
            pending_q <= '0;
        end else begin
            src_q     <= src_i;
            src_d     <= src_q;
            pending_q <= (pending_q & ~clr) | rise;  // New edge beats the clear
        end
    end

    assign pending_o = pending_q;

endmodule

//--- src/intr_arbiter.sv
// Lowest index interrupt arbiter
module intr_arbiter #(
    parameter int NUM_BLOCKS = intr_pkg::NUM_BLOCKS
) (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic [intr_pkg::SRC_PER_BLK*NUM_BLOCKS-1:0]  pending_i,
    output logic                                         claim_valid_o,
    output intr_pkg::src_idx_u                           claim_idx_o,
    output logic                                         sel_valid_o,
    output intr_pkg::src_idx_u                           sel_idx_o,
    input  logic                                         sel_ready_i
);

    import intr_pkg::*;

    localparam int N_SRC = SRC_PER_BLK * NUM_BLOCKS;

    logic     any_pend;
    logic     load;
    src_idx_u low_idx;
    logic     sel_valid_q;
    src_idx_u sel_idx_q;  // Holding register

    // ------------------------------
    // Priority pick
    // ------------------------------
    // Scan from the top so the lowest set bit is written last
    always_comb begin
        low_idx = '0;
        for (int i = N_SRC - 1; i >= 0; i--) begin
            if (pending_i[i]) begin
                low_idx.flat = SRC_IDX_W'(i);
            end
        end
    end

    assign any_pend = |pending_i;

    // Slot free, or draining into delivery this cycle
    assign load = any_pend && (!sel_valid_q || sel_ready_i);

    // Claim pulses with the load, capture clears on the same edge
    assign claim_valid_o = load;
    assign claim_idx_o   = low_idx;

    // ------------------------------
    // Holding register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sel_valid_q <= 1'b0;
        end else if (load) begin
            sel_valid_q <= 1'b1;
        end else if (sel_ready_i) begin
            sel_valid_q <= 1'b0;      // Taken with nothing to refill
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sel_idx_q <= low_idx;
        end
    end

    assign sel_valid_o = sel_valid_q;
    assign sel_idx_o   = sel_idx_q;

endmodule

//--- src/intr_delivery.sv
// Interrupt vector delivery
module intr_delivery (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       sel_valid_i,
    input  intr_pkg::src_idx_u         sel_idx_i,
    output logic                       sel_ready_o,
    output logic                       intr_req_o,
    input  logic                       intr_ack_i,
    output logic [intr_pkg::VEC_W-1:0] intr_vec_o,
    output logic                       intr_notif_o
);

    import intr_pkg::*;

    // ------------------------------
    // Handshake states
    // ------------------------------
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_REQ      = 2'd1;  // req high, waiting for ack
    localparam logic [1:0] ST_WAIT_LOW = 2'd2;  // req low, waiting for ack to drop
    localparam logic [1:0] ST_DONE     = 2'd3;  // One cycle before idle

    logic [1:0]       state_q;
    logic [1:0]       state_d;
    logic             xfer;
    logic [VEC_W-1:0] vec_q;
    logic             notif_q;

    assign sel_ready_o = (state_q == ST_IDLE);
    assign xfer        = sel_valid_i && sel_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (xfer) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (intr_ack_i) begin
                    state_d = ST_WAIT_LOW;
                end
            end
            ST_WAIT_LOW: begin
                if (!intr_ack_i) begin
                    state_d = ST_DONE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // Vector payload
    // ------------------------------
    // Vector 0 is reserved by the core, so index i goes out as i+1
    always_ff @(posedge clk) begin
        if (xfer) begin
            vec_q   <= VEC_W'(sel_idx_i.flat) + VEC_W'(1);
            notif_q <= sel_idx_i.src.kind;
        end
    end

    assign intr_req_o   = (state_q == ST_REQ);
    assign intr_vec_o   = vec_q;    // Stable through the whole request
    assign intr_notif_o = notif_q;

endmodule

//--- src/intr_top.sv
// Interrupt aggregator top
module intr_top #(
    parameter int NUM_BLOCKS = intr_pkg::NUM_BLOCKS  // aes, ecc, hmac, sha512, mbox
) (
    input  logic                                         clk,
    input  logic                                         rst_i,
    // Source 2*b is block b error, 2*b+1 is block b notif
    input  logic [intr_pkg::SRC_PER_BLK*NUM_BLOCKS-1:0]  src_i,
    output logic                                         intr_req_o,
    input  logic                                         intr_ack_i,
    output logic [intr_pkg::VEC_W-1:0]                   intr_vec_o,
    output logic                                         intr_notif_o
);

    import intr_pkg::*;

    localparam int N_SRC = SRC_PER_BLK * NUM_BLOCKS;

    logic [N_SRC-1:0] pending;
    logic             claim_valid;
    src_idx_u         claim_idx;
    logic             sel_valid;
    logic             sel_ready;
    src_idx_u         sel_idx;

    // ------------------------------
    // Edge capture
    // ------------------------------
    intr_capture #(
        .NUM_BLOCKS    (NUM_BLOCKS)
    ) u_capture (
        .clk           (clk),
        .rst_i         (rst_i),
        .src_i         (src_i),
        .claim_valid_i (claim_valid),
        .claim_idx_i   (claim_idx),
        .pending_o     (pending)
    );

    // ------------------------------
    // Selection
    // ------------------------------
    intr_arbiter #(
        .NUM_BLOCKS    (NUM_BLOCKS)
    ) u_arbiter (
        .clk           (clk),
        .rst_i         (rst_i),
        .pending_i     (pending),
        .claim_valid_o (claim_valid),
        .claim_idx_o   (claim_idx),
        .sel_valid_o   (sel_valid),
        .sel_idx_o     (sel_idx),
        .sel_ready_i   (sel_ready)
    );

    // ------------------------------
    // Core handshake
    // ------------------------------
    intr_delivery u_delivery (
        .clk           (clk),
        .rst_i         (rst_i),
        .sel_valid_i   (sel_valid),
        .sel_idx_i     (sel_idx),
        .sel_ready_o   (sel_ready),
        .intr_req_o    (intr_req_o),
        .intr_ack_i    (intr_ack_i),
        .intr_vec_o    (intr_vec_o),
        .intr_notif_o  (intr_notif_o)
    );

endmodule

//--- sim/tb_clock.sv
// Testbench clock and reset
module tb_clock #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Synchronous reset, released right after the last reset edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- sim/tb_intr_top.sv
// Interrupt aggregator testbench
module tb_intr_top;

    import intr_pkg::*;

    localparam int QUIET_CYC    = 12;   // Must stay silent after the last delivery
    localparam int CYC_PER_TEST = 200;

    logic               clk;
    logic               rst;
    logic [NUM_SRC-1:0] src_i = '0;
    logic               intr_ack_i = 1'b0;
    logic               intr_req_o;
    logic [VEC_W-1:0]   intr_vec_o;
    logic               intr_notif_o;

    // Pattern table of pulse mask, ack delay and first vector
    logic [NUM_SRC-1:0] pat_mask [$];
    logic [7:0]         pat_delay [$];
    logic [VEC_W-1:0]   pat_first [$];

    // Requests seen by the monitor in arrival order
    logic [VEC_W-1:0]   got_vec_q [$];
    logic               got_notif_q [$];

    int                 error_count = 0;
    int                 check_count = 0;
    int                 mon_errors = 0;
    int                 mon_checks = 0;

    logic [7:0]         delay_cfg = 8'h00;    // FF selects a random delay
    int                 cur_delay = 0;
    int                 wait_cnt = 0;
    logic               in_req = 1'b0;
    logic [15:0]        lfsr_q = 16'd44497;
    logic               req_seen = 1'b0;
    logic [VEC_W-1:0]   held_vec = '0;

    tb_clock #(
        .PERIOD     (20),
        .RST_CYCLES (5)
    ) i_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    intr_top #(
        .NUM_BLOCKS   (NUM_BLOCKS)
    ) i_dut (
        .clk          (clk),
        .rst_i        (rst),
        .src_i        (src_i),
        .intr_req_o   (intr_req_o),
        .intr_ack_i   (intr_ack_i),
        .intr_vec_o   (intr_vec_o),
        .intr_notif_o (intr_notif_o)
    );

    // ------------------------------
    // Random delays
    // ------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // ------------------------------
    // Core model
    // ------------------------------
    always @(negedge clk) begin
        if (rst) begin
            intr_ack_i <= 1'b0;
            in_req = 1'b0;
        end else if (!intr_ack_i) begin
            if (intr_req_o) begin
                if (!in_req) begin
                    in_req = 1'b1;
                    wait_cnt = 0;
                    if (delay_cfg == 8'hFF) begin
                        random_bits(4, cur_delay);
                    end else begin
                        cur_delay = int'(delay_cfg);
                    end
                end
                if (wait_cnt >= cur_delay) begin
                    intr_ack_i <= 1'b1;
                end else begin
                    wait_cnt++;
                end
            end
        end else if (!intr_req_o) begin
            // Ack release waits the same delay after req drops
            if (in_req) begin
                in_req = 1'b0;
                wait_cnt = 0;
            end
            if (wait_cnt >= cur_delay) begin
                intr_ack_i <= 1'b0;          // Phase four
            end else begin
                wait_cnt++;
            end
        end
    end

    // Request monitor that also watches the four-phase rule
    always @(negedge clk) begin
        if (rst) begin
            req_seen = 1'b0;
        end else begin
            if (intr_req_o && !req_seen) begin
                mon_checks++;
                if (intr_ack_i) begin
                    mon_errors++;
                    $display("Request rose while the acknowledge was still high");
                end
                held_vec = intr_vec_o;
                got_vec_q.push_back(intr_vec_o);
                got_notif_q.push_back(intr_notif_o);
            end else if (intr_req_o) begin
                mon_checks++;
                if (intr_vec_o !== held_vec) begin
                    mon_errors++;
                    $display("Error: intr_vec_o got 0x%h expected 0x%h during request",
                             intr_vec_o, held_vec);
                end
            end
            req_seen = intr_req_o;
        end
    end

    // ------------------------------
    // Checks and test steps
    // ------------------------------
    task automatic check_hex(input string name, input int t, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: test %0d %s got 0x%0h expected 0x%0h", t, name, got, exp);
        end
    endtask

    task automatic read_patterns();
        int                 fd;
        int                 n;
        string              line;
        logic [NUM_SRC-1:0] m;
        logic [7:0]         d;
        logic [VEC_W-1:0]   v;
        fd = $fopen("sim/intr_patterns.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the pattern file sim/intr_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h", m, d, v);
                    if (n == 3) begin
                        pat_mask.push_back(m);
                        pat_delay.push_back(d);
                        pat_first.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        int exp_idx [$];
        int base;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (pat_mask[t][i]) begin
                exp_idx.push_back(i);  // Lowest index first
            end
        end
        base = got_vec_q.size();
        delay_cfg = pat_delay[t];
        @(negedge clk);
        src_i <= pat_mask[t];
        @(negedge clk);
        src_i <= '0;
        while (got_vec_q.size() < base + exp_idx.size()) @(negedge clk);
        while (intr_req_o || intr_ack_i) @(negedge clk);
        repeat (QUIET_CYC) @(negedge clk);
        check_count++;
        if (got_vec_q.size() != base + exp_idx.size()) begin
            error_count++;
            $display("Test %0d expected %0d requests but saw %0d", t, exp_idx.size(),
                     got_vec_q.size() - base);
        end else begin
            for (int k = 0; k < exp_idx.size(); k++) begin
                check_hex("intr_vec_o", t, 32'(got_vec_q[base + k]), 32'(exp_idx[k] + 1));
                check_hex("intr_notif_o", t, 32'(got_notif_q[base + k]), 32'(exp_idx[k] % 2));
            end
            if (exp_idx.size() > 0) begin
                check_hex("intr_vec_o first", t, 32'(got_vec_q[base]), 32'(pat_first[t]));
            end
        end
    endtask

    task automatic report_counts();
        $display("Tests: %0d  checks: %0d  errors: %0d", pat_mask.size(),
                 check_count + mon_checks, error_count + mon_errors);
    endtask

    initial begin
        read_patterns();
        if (pat_mask.size() == 0) begin
            error_count++;
            $display("No test patterns were read");
        end
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (10) begin                  // Nothing pulses yet
            @(negedge clk);
            check_hex("intr_req_o", 0, 32'(intr_req_o), 32'h0);
        end
        for (int t = 0; t < pat_mask.size(); t++) begin
            run_test(t);
        end
        report_counts();
        if (error_count + mon_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        #1;
        repeat ((pat_mask.size() + 1) * CYC_PER_TEST) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        report_counts();
        $display("Something failed");
        $finish;
    end

endmodule

//--- sim/intr_patterns.txt
# Columns: pulse mask (hex, bit i is source i), ack delay (hex, FF is random),
# expected first vector (hex, source index + 1)
001 00 01
002 00 02
004 01 03
008 02 04
010 00 05
020 03 06
040 00 07
080 05 08
100 00 09
200 02 0a
200 00 0a
001 00 01
001 04 01
3ff 00 01
2aa 01 02
155 03 01
300 00 09
0f0 02 05
204 00 03
180 04 08
3ff ff 01
2c1 ff 01
11e ff 02
0a0 ff 06
3c0 ff 07
055 ff 01
3ff ff 01

//--- intr_agg.f
src/intr_pkg.sv
src/intr_capture.sv
src/intr_arbiter.sv
src/intr_delivery.sv
src/intr_top.sv
sim/tb_clock.sv
sim/tb_intr_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_intr_top -f intr_agg.f -o tb_intr_top \
    && ./obj_dir/tb_intr_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
